// File: filelist.f
+incdir+include
src/fetch_pkg.sv
src/fetch_fifo.sv
src/prefetch_buffer.sv
src/fetch_pc_gen.sv
src/instr_fetch_top.sv
dv/instr_mem_model.sv
dv/tb_instr_fetch.sv

// File: dv/tb_instr_fetch.sv
/*
  Testbench for the instruction fetch front end.
  Random decode stalls and redirects against a random-latency memory model,
  with a reference model of the expected address, data and tag stream.
*/
`timescale 1ns/1ps
`include "fetch_consts.svh"

module tb_instr_fetch;

  localparam int unsigned SEED       = 32'h6b48_920a;
  localparam int unsigned RUN_CYCLES = 3000;
  localparam int unsigned DRAIN_MAX  = 200;
  localparam logic [`FETCH_DATA_W-1:0] DATA_KEY = 32'h5a5a_0f0f;

  logic                      clk;
  logic                      rst_n;
  logic                      fetch_en;
  logic                      redirect;
  logic [`FETCH_ADDR_W-1:0]  redirect_addr;
  logic                      ready;
  logic                      valid;
  logic [`FETCH_ADDR_W-1:0]  addr;
  logic [`FETCH_DATA_W-1:0]  rdata;
  fetch_pkg::fetch_tag_t     tag;
  logic                      busy;
  logic                      instr_req;
  logic [`FETCH_ADDR_W-1:0]  instr_addr;
  logic                      instr_gnt;
  logic [`FETCH_DATA_W-1:0]  instr_rdata;
  logic                      instr_rvalid;

  // reference model state
  logic [`FETCH_ADDR_W-1:0]  exp_addr;
  logic [`FETCH_EPOCH_W-1:0] exp_epoch;
  logic                      exp_first;
  // output held by a stall at the previous edge
  logic                      hold_q;
  logic [`FETCH_ADDR_W-1:0]  hold_addr;
  logic [`FETCH_DATA_W-1:0]  hold_rdata;
  fetch_pkg::fetch_tag_t     hold_tag;
  logic                      redirect_q;

  // expected FIFO fill and grant wait behind busy_o
  int unsigned               fifo_cnt;
  logic                      gnt_wait_q;
  // request raised and its response not yet back
  logic                      req_open;
  logic                      req_dropped;
  logic                      exp_busy;

  int unsigned gnt_cnt;
  int unsigned rvalid_cnt;
  int unsigned items;
  int unsigned value_errors;
  int unsigned protocol_errors;
  bit          drained;
  bit          timed_out;

  instr_fetch_top DUT (
    .clk_i           (clk),
    .rst_ni          (rst_n),
    .fetch_en_i      (fetch_en),
    .redirect_i      (redirect),
    .redirect_addr_i (redirect_addr),
    .ready_i         (ready),
    .valid_o         (valid),
    .addr_o          (addr),
    .rdata_o         (rdata),
    .tag_o           (tag),
    .busy_o          (busy),
    .instr_req_o     (instr_req),
    .instr_addr_o    (instr_addr),
    .instr_gnt_i     (instr_gnt),
    .instr_rdata_i   (instr_rdata),
    .instr_rvalid_i  (instr_rvalid)
  );

  instr_mem_model u_mem (
    .clk_i    (clk),
    .rst_ni   (rst_n),
    .req_i    (instr_req),
    .addr_i   (instr_addr),
    .gnt_o    (instr_gnt),
    .rdata_o  (instr_rdata),
    .rvalid_o (instr_rvalid)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
    value_errors++;
    $display("Error: %s is %h, expected %h (time %0t)", name, got, exp, $time);
  endtask

  task automatic report_violation(input string what);
    protocol_errors++;
    $display("Protocol violation at time %0t: %s", $time, what);
  endtask

  // --------------------
  // monitor and reference model
  // --------------------

  // sampled at the rising edge, where every handshake takes effect
  always @(posedge clk) begin
    if (!rst_n) begin
      exp_addr    = '0;
      exp_epoch   = '0;
      exp_first   = 1'b1;
      hold_q      = 1'b0;
      redirect_q  = 1'b0;
      fifo_cnt    = 0;
      gnt_wait_q  = 1'b0;
      req_open    = 1'b0;
      req_dropped = 1'b0;
    end else begin
      // at most one memory request in flight
      if (instr_rvalid) begin
        if (gnt_cnt == rvalid_cnt) report_violation("rvalid with no granted request open");
        rvalid_cnt++;
      end
      if (instr_req && instr_gnt) begin
        if (gnt_cnt != rvalid_cnt) report_violation("request granted while another is open");
        gnt_cnt++;
      end
      // busy while a grant is pending or the FIFO is full
      exp_busy = gnt_wait_q || (fifo_cnt == `FETCH_FIFO_DEPTH);
      if (busy !== exp_busy) report_mismatch("busy_o", busy, exp_busy);
      // FIFO was cleared by the redirect one edge ago
      if (redirect_q && valid) report_mismatch("valid_o after redirect", valid, 0);
      // stalled output must not move
      if (hold_q) begin
        if (!valid) report_mismatch("valid_o under stall", valid, 1);
        if (addr !== hold_addr) report_mismatch("addr_o under stall", addr, hold_addr);
        if (rdata !== hold_rdata) report_mismatch("rdata_o under stall", rdata, hold_rdata);
        if (tag !== hold_tag) report_mismatch("tag_o under stall", tag, hold_tag);
      end
      // a live response is written into the FIFO
      if (instr_rvalid) begin
        if (!redirect && !req_dropped) fifo_cnt++;
        req_open = 1'b0;
      end
      // an item moves only when no redirect clears the FIFO
      if (valid && ready && !redirect) begin
        if (addr !== exp_addr) report_mismatch("addr_o", addr, exp_addr);
        if (rdata !== (addr[`FETCH_DATA_W-1:0] ^ DATA_KEY))
          report_mismatch("rdata_o", rdata, addr[`FETCH_DATA_W-1:0] ^ DATA_KEY);
        if (tag.epoch !== exp_epoch) report_mismatch("tag_o.epoch", tag.epoch, exp_epoch);
        if (tag.first !== exp_first) report_mismatch("tag_o.first", tag.first, exp_first);
        items++;
        fifo_cnt--;
        exp_addr  = exp_addr + 4;
        exp_first = 1'b0;
      end
      // a new request starts
      if (instr_req && !req_open) begin
        req_open    = 1'b1;
        req_dropped = 1'b0;
      end
      // sequence restarts at the target under the next epoch
      if (redirect) begin
        exp_addr  = redirect_addr;
        exp_epoch = exp_epoch + 1'b1;
        exp_first = 1'b1;
        fifo_cnt  = 0;
        // the response still owed belongs to the old epoch
        if (req_open) req_dropped = 1'b1;
      end
      gnt_wait_q = instr_req && !instr_gnt;
      hold_q     = valid && !ready && !redirect;
      hold_addr  = addr;
      hold_rdata = rdata;
      hold_tag   = tag;
      redirect_q = redirect;
    end
  end

  // --------------------
  // stimulus
  // --------------------

  initial begin
    void'($urandom(SEED));
    rst_n           = 1'b0;
    fetch_en        = 1'b0;
    redirect        = 1'b0;
    redirect_addr   = '0;
    ready           = 1'b0;
    gnt_cnt         = 0;
    rvalid_cnt      = 0;
    items           = 0;
    value_errors    = 0;
    protocol_errors = 0;
    drained         = 1'b0;
    timed_out       = 1'b0;

    repeat (16) @(negedge clk);
    rst_n = 1'b1;

    // inputs change on the falling edge only
    for (int c = 0; c < RUN_CYCLES; c++) begin
      ready    = ($urandom_range(99, 0) < 70);
      fetch_en = ($urandom_range(99, 0) < 95);
      // single-cycle pulses that never come back to back
      if (!redirect && ($urandom_range(99, 0) < 2)) begin
        redirect      = 1'b1;
        redirect_addr = {$urandom, $urandom};
        redirect_addr[1:0] = 2'b00;
      end else begin
        redirect = 1'b0;
      end
      @(negedge clk);
    end

    // stop fetching and let decode take everything
    redirect = 1'b0;
    fetch_en = 1'b0;
    ready    = 1'b1;
    for (int w = 0; w < DRAIN_MAX && !drained; w++) begin
      @(negedge clk);
      if (!valid && !instr_req && gnt_cnt == rvalid_cnt) drained = 1'b1;
    end
    if (!drained) begin
      timed_out = 1'b1;
      $display("Timeout: fetch outputs did not drain within %0d cycles", DRAIN_MAX);
    end
    if (items == 0) report_violation("no output item was accepted during the run");

    $display("value errors %0d, protocol errors %0d, timeout %0d (items %0d, grants %0d)",
             value_errors, protocol_errors, timed_out, items, gnt_cnt);
    if (value_errors == 0 && protocol_errors == 0 && !timed_out) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// File: dv/instr_mem_model.sv
/*
  Instruction memory model for the fetch testbench.
  Grants at random and answers each grant 1 to 3 cycles later with address-derived data.
*/
`timescale 1ns/1ps
`include "fetch_consts.svh"

module instr_mem_model (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     req_i,
  input  logic [`FETCH_ADDR_W-1:0] addr_i,
  output logic                     gnt_o,
  output logic [`FETCH_DATA_W-1:0] rdata_o,
  output logic                     rvalid_o
);

  // data word is the low address bits scrambled with this key
  localparam logic [`FETCH_DATA_W-1:0] DATA_KEY = 32'h5a5a_0f0f;

  logic                     gnt_roll;
  // request accepted at the last rising edge
  logic                     gnt_seen;
  logic [`FETCH_ADDR_W-1:0] gnt_addr;
  // response owed and cycles left before it goes out
  logic                     pend;
  logic [1:0]               wait_cnt;
  logic [`FETCH_ADDR_W-1:0] pend_addr;

  initial begin
    gnt_roll  = 1'b0;
    gnt_seen  = 1'b0;
    gnt_addr  = '0;
    pend      = 1'b0;
    wait_cnt  = '0;
    pend_addr = '0;
    rvalid_o  = 1'b0;
    rdata_o   = '0;
  end

  // grant follows the request level, 60 % of cycles
  assign gnt_o = req_i && gnt_roll;

  always @(posedge clk_i) begin
    gnt_seen <= rst_ni && req_i && gnt_o;
    gnt_addr <= addr_i;
  end

  // all memory outputs change on the falling edge
  always @(negedge clk_i) begin
    gnt_roll <= ($urandom_range(99, 0) < 60);
    rvalid_o <= 1'b0;
    if (!rst_ni) begin
      pend = 1'b0;
    end else begin
      if (gnt_seen) begin
        pend      = 1'b1;
        pend_addr = gnt_addr;
        // 0 here means rvalid at the very next rising edge
        wait_cnt  = $urandom_range(2, 0);
      end
      if (pend) begin
        if (wait_cnt == 0) begin
          rvalid_o <= 1'b1;
          rdata_o  <= pend_addr[`FETCH_DATA_W-1:0] ^ DATA_KEY;
          pend     = 1'b0;
        end else begin
          wait_cnt = wait_cnt - 1'b1;
        end
      end
    end
  end

endmodule

// File: src/instr_fetch_top.sv
/*
  Instruction fetch front end top level.
  Connects the PC generator, the prefetch buffer and the fetch FIFO.
*/
`timescale 1ns/1ps
`include "fetch_consts.svh"

module instr_fetch_top (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      fetch_en_i,
  input  logic                      redirect_i,
  input  logic [`FETCH_ADDR_W-1:0]  redirect_addr_i,

  // decode side
  input  logic                      ready_i,
  output logic                      valid_o,
  output logic [`FETCH_ADDR_W-1:0]  addr_o,
  output logic [`FETCH_DATA_W-1:0]  rdata_o,
  output fetch_pkg::fetch_tag_t     tag_o,
  output logic                      busy_o,

  // instruction memory
  output logic                      instr_req_o,
  output logic [`FETCH_ADDR_W-1:0]  instr_addr_o,
  input  logic                      instr_gnt_i,
  input  logic [`FETCH_DATA_W-1:0]  instr_rdata_i,
  input  logic                      instr_rvalid_i
);

  // PC generator to prefetch buffer
  logic [`FETCH_ADDR_W-1:0]  fetch_addr;
  fetch_pkg::fetch_tag_t     fetch_tag;
  logic                      addr_taken;

  // prefetch buffer to FIFO
  logic                      fifo_valid;
  logic                      fifo_ready;
  logic [`FETCH_ADDR_W-1:0]  fifo_addr;
  logic [`FETCH_DATA_W-1:0]  fifo_rdata;
  fetch_pkg::fetch_tag_t     fifo_tag;

  fetch_pc_gen u_pc_gen (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .redirect_i      (redirect_i),
    .redirect_addr_i (redirect_addr_i),
    .addr_taken_i    (addr_taken),
    .fetch_addr_o    (fetch_addr),
    .fetch_tag_o     (fetch_tag)
  );

  // fetch enable is the valid level of the next address
  prefetch_buffer u_prefetch (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .flush_i        (redirect_i),
    .fetch_valid_i  (fetch_en_i),
    .fetch_addr_i   (fetch_addr),
    .fetch_tag_i    (fetch_tag),
    .addr_taken_o   (addr_taken),
    .fifo_ready_i   (fifo_ready),
    .fifo_valid_o   (fifo_valid),
    .fifo_addr_o    (fifo_addr),
    .fifo_rdata_o   (fifo_rdata),
    .fifo_tag_o     (fifo_tag),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rdata_i  (instr_rdata_i),
    .instr_rvalid_i (instr_rvalid_i),
    .busy_o         (busy_o)
  );

  fetch_fifo u_fifo (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .clear_i     (redirect_i),
    .in_valid_i  (fifo_valid),
    .in_addr_i   (fifo_addr),
    .in_rdata_i  (fifo_rdata),
    .in_tag_i    (fifo_tag),
    .in_ready_o  (fifo_ready),
    .out_valid_o (valid_o),
    .out_ready_i (ready_i),
    .out_addr_o  (addr_o),
    .out_rdata_o (rdata_o),
    .out_tag_o   (tag_o)
  );

endmodule

// File: src/fetch_pc_gen.sv
/*
  Fetch address and redirect epoch generator.
  Advances by one word per accepted request and reloads on a redirect.
*/
`timescale 1ns/1ps
`include "fetch_consts.svh"

module fetch_pc_gen (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      redirect_i,
  input  logic [`FETCH_ADDR_W-1:0]  redirect_addr_i,
  input  logic                      addr_taken_i,
  output logic [`FETCH_ADDR_W-1:0]  fetch_addr_o,
  output fetch_pkg::fetch_tag_t     fetch_tag_o
);

  // one 32-bit instruction per fetch
  localparam logic [`FETCH_ADDR_W-1:0] INSTR_BYTES = 4;

  logic [`FETCH_ADDR_W-1:0]  pc_q;
  logic [`FETCH_EPOCH_W-1:0] epoch_q;
  // next fetch is the first of its epoch
  logic                      first_q;

  // --------------------
  // address and epoch
  // --------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pc_q    <= '0;
      epoch_q <= '0;
      first_q <= 1'b1;
    end else if (redirect_i) begin
      // redirect wins over a taken address
      pc_q    <= redirect_addr_i;
      epoch_q <= epoch_q + 1'b1;
      first_q <= 1'b1;
    end else if (addr_taken_i) begin
      pc_q    <= pc_q + INSTR_BYTES;
      first_q <= 1'b0;
    end
  end

  assign fetch_addr_o      = pc_q;
  assign fetch_tag_o.epoch = epoch_q;
  assign fetch_tag_o.first = first_q;

endmodule

// File: src/prefetch_buffer.sv
/*
  Instruction memory request FSM with one request outstanding at a time.
  Latches the fetch address and tag at request start, writes responses into the
  fetch FIFO and drops responses that belong to a flushed epoch.
*/
`timescale 1ns/1ps
`include "fetch_consts.svh"

module prefetch_buffer (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      flush_i,

  // next fetch address from the PC generator
  input  logic                      fetch_valid_i,
  input  logic [`FETCH_ADDR_W-1:0]  fetch_addr_i,
  input  fetch_pkg::fetch_tag_t     fetch_tag_i,
  output logic                      addr_taken_o,

  // write side of the fetch FIFO
  input  logic                      fifo_ready_i,
  output logic                      fifo_valid_o,
  output logic [`FETCH_ADDR_W-1:0]  fifo_addr_o,
  output logic [`FETCH_DATA_W-1:0]  fifo_rdata_o,
  output fetch_pkg::fetch_tag_t     fifo_tag_o,

  // instruction memory port
  output logic                      instr_req_o,
  output logic [`FETCH_ADDR_W-1:0]  instr_addr_o,
  input  logic                      instr_gnt_i,
  input  logic [`FETCH_DATA_W-1:0]  instr_rdata_i,
  input  logic                      instr_rvalid_i,

  output logic                      busy_o
);

  fetch_pkg::fetch_state_e state_q;
  fetch_pkg::fetch_state_e state_d;

  // flush seen while the request still waits for its grant
  logic abort_q;
  logic abort_d;

  // address and tag of the request in flight
  logic [`FETCH_ADDR_W-1:0] addr_q;
  fetch_pkg::fetch_tag_t    tag_q;

  // --------------------
  // status
  // --------------------

  // stalled on the grant, or no room for another word
  assign busy_o = (state_q == fetch_pkg::WAIT_GNT) || !fifo_ready_i;

  // the response belongs to the latched request
  assign fifo_addr_o  = addr_q;
  assign fifo_tag_o   = tag_q;
  assign fifo_rdata_o = instr_rdata_i;

  // --------------------
  // request FSM
  // --------------------

  always_comb begin
    state_d      = state_q;
    abort_d      = abort_q;
    instr_req_o  = 1'b0;
    instr_addr_o = fetch_addr_i;
    addr_taken_o = 1'b0;
    fifo_valid_o = 1'b0;

    unique case (state_q)
      fetch_pkg::IDLE: begin
        // new request only with a free FIFO slot, so the response always fits
        // nothing is issued while the PC is being reloaded
        if (fetch_valid_i && fifo_ready_i && !flush_i) begin
          instr_req_o  = 1'b1;
          addr_taken_o = 1'b1;
          if (instr_gnt_i) begin
            state_d = fetch_pkg::WAIT_RVALID;
          end else begin
            state_d = fetch_pkg::WAIT_GNT;
          end
        end
      end

      fetch_pkg::WAIT_GNT: begin
        // request must stay up on the latched address until granted
        instr_req_o  = 1'b1;
        instr_addr_o = addr_q;
        if (instr_gnt_i) begin
          abort_d = 1'b0;
          // a flush now or earlier kills the coming response
          if (flush_i || abort_q) begin
            state_d = fetch_pkg::WAIT_ABORTED;
          end else begin
            state_d = fetch_pkg::WAIT_RVALID;
          end
        end else if (flush_i) begin
          abort_d = 1'b1;
        end
      end

      fetch_pkg::WAIT_RVALID: begin
        if (instr_rvalid_i) begin
          // data arriving together with a flush is stale
          fifo_valid_o = !flush_i;
          state_d      = fetch_pkg::IDLE;
        end else if (flush_i) begin
          state_d = fetch_pkg::WAIT_ABORTED;
        end
      end

      fetch_pkg::WAIT_ABORTED: begin
        // swallow the old response, then fetch again
        if (instr_rvalid_i) begin
          state_d = fetch_pkg::IDLE;
        end
      end

      default: begin
        state_d = fetch_pkg::IDLE;
      end
    endcase
  end

  // --------------------
  // registers
  // --------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= fetch_pkg::IDLE;
      abort_q <= 1'b0;
    end else begin
      state_q <= state_d;
      abort_q <= abort_d;
    end
  end

  // capture address and tag when a request starts
  always_ff @(posedge clk_i) begin
    if (addr_taken_o) begin
      addr_q <= fetch_addr_i;
      tag_q  <= fetch_tag_i;
    end
  end

  // --------------------
  // assertions
  // --------------------

  // request and address hold until granted
  a_req_stable: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (instr_req_o && !instr_gnt_i) |=> (instr_req_o && $stable(instr_addr_o))
  ) else $error("request dropped or address changed before grant");

  // every response must match a granted request
  a_no_rvalid_idle: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (state_q == fetch_pkg::IDLE) |-> !instr_rvalid_i
  ) else $error("rvalid without an outstanding request");

  // a written word always carries the epoch the PC generator is in now
  a_write_current_epoch: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    fifo_valid_o |-> (fifo_tag_o.epoch == fetch_tag_i.epoch)
  ) else $error("word from an old epoch written into the FIFO");

endmodule

// File: src/fetch_fifo.sv
/*
  Fetch FIFO between the instruction memory and the decode stage.
  Stores address, instruction word and fetch tag; clear_i empties it on a redirect.
*/
`timescale 1ns/1ps
`include "fetch_consts.svh"

module fetch_fifo (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      clear_i,

  // write side, from the prefetch buffer
  input  logic                      in_valid_i,
  input  logic [`FETCH_ADDR_W-1:0]  in_addr_i,
  input  logic [`FETCH_DATA_W-1:0]  in_rdata_i,
  input  fetch_pkg::fetch_tag_t     in_tag_i,
  output logic                      in_ready_o,

  // read side, towards decode
  output logic                      out_valid_o,
  input  logic                      out_ready_i,
  output logic [`FETCH_ADDR_W-1:0]  out_addr_o,
  output logic [`FETCH_DATA_W-1:0]  out_rdata_o,
  output fetch_pkg::fetch_tag_t     out_tag_o
);

  localparam int unsigned DEPTH = `FETCH_FIFO_DEPTH;
  localparam int unsigned PTR_W = $clog2(DEPTH);

  // --------------------
  // storage
  // --------------------

  // payload of each entry
  logic [`FETCH_ADDR_W-1:0]  addr_mem  [DEPTH];
  logic [`FETCH_DATA_W-1:0]  rdata_mem [DEPTH];
  fetch_pkg::fetch_tag_t     tag_mem   [DEPTH];

  // pointers wrap naturally since depth is a power of two
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  // one extra bit so that full can be told from empty
  logic [PTR_W:0]   count_q;

  logic push;
  logic pop;

  // --------------------
  // status and handshake
  // --------------------

  assign in_ready_o  = (count_q != DEPTH[PTR_W:0]);
  assign out_valid_o = (count_q != '0);

  // a write or a read on a clear cycle is dropped
  assign push = in_valid_i && in_ready_o && !clear_i;
  assign pop  = out_valid_o && out_ready_i && !clear_i;

  // head entry straight from the array, stable until popped
  assign out_addr_o  = addr_mem[rd_ptr_q];
  assign out_rdata_o = rdata_mem[rd_ptr_q];
  assign out_tag_o   = tag_mem[rd_ptr_q];

  // --------------------
  // pointers and count
  // --------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (clear_i) begin
      // redirect flushes everything
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      // simultaneous push and pop leaves the count unchanged
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // write port of the storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      addr_mem[wr_ptr_q]  <= in_addr_i;
      rdata_mem[wr_ptr_q] <= in_rdata_i;
      tag_mem[wr_ptr_q]   <= in_tag_i;
    end
  end

  // --------------------
  // assertions
  // --------------------

  // the prefetch buffer only requests with a free slot, so a full write is a bug upstream
  a_no_write_full: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    in_valid_i |-> in_ready_o
  ) else $error("fetch FIFO written while full");

  // decode must never see a stale word after a redirect
  a_empty_after_clear: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    clear_i |=> !out_valid_o
  ) else $error("fetch FIFO not empty on the cycle after a clear");

endmodule

// File: src/fetch_pkg.sv
/*
  Shared types of the instruction fetch front end.
  Holds the per-word fetch tag and the prefetch FSM state encoding.
*/
`include "fetch_consts.svh"

package fetch_pkg;

  // --------------------
  // fetch tag
  // --------------------

  // travels with every fetched word from the PC generator to decode
  typedef struct packed {
    // redirect epoch the word was requested under
    logic [`FETCH_EPOCH_W-1:0] epoch;
    // first fetch after a redirect or after reset
    logic                      first;
  } fetch_tag_t;

  // --------------------
  // prefetch FSM
  // --------------------

  // IDLE          no request outstanding
  // WAIT_GNT      request up, grant not yet seen
  // WAIT_RVALID   granted, response will be written
  // WAIT_ABORTED  granted, response will be dropped
  typedef enum logic [1:0] {
    IDLE,
    WAIT_GNT,
    WAIT_RVALID,
    WAIT_ABORTED
  } fetch_state_e;

endpackage

// File: include/fetch_consts.svh
/*
  Width and depth constants for the instruction fetch front end.
  Included by the fetch package and by every fetch RTL module.
*/
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// instruction address width in bits
`define FETCH_ADDR_W 64

// instruction word width in bits
`define FETCH_DATA_W 32

// redirect epoch width carried in each fetch tag
`define FETCH_EPOCH_W 2

// fetch FIFO entries, power of two and at least 2
`define FETCH_FIFO_DEPTH 4

`endif
